/* rtl/audio_cfg.svh */
//************************************************************
// Build-time constants of the audio playback path.
// Addresses are 4 bits wide; the divider counts i_clock cycles.
//************************************************************

`ifndef AUDIO_CFG_SVH
`define AUDIO_CFG_SVH

// Samples held by the playback FIFO.
`define AUDIO_FIFO_DEPTH 8

// Divider after reset, in i_clock cycles per bit-clock half period.
`define AUDIO_DEFAULT_DIVIDER 16'd17

// CPU register map.
`define AUDIO_ADDR_DATA     4'd0
`define AUDIO_ADDR_DIVIDER  4'd1
`define AUDIO_ADDR_UNDERRUN 4'd2

`endif

/* rtl/audio_pkg.sv */
//************************************************************
// Shared types of the audio playback path.
// Sample halves are signed 16-bit PCM, left in the upper half.
//************************************************************

package audio_pkg;

	// One stereo frame as it sits in the FIFO.
	// Left is the upper half of the bus word.
	typedef struct packed {
		logic signed [15:0] left;
		logic signed [15:0] right;
	} stereo_sample_t;

	// Fields the CPU holds steady while i_request is high.
	typedef struct packed {
		logic        rw;
		logic [3:0]  address;
		logic [31:0] wdata;
	} bus_req_t;

	// Unused flag bits of a bus word are read as zero.
	typedef logic [31:0] bus_word_t;

endpackage

/* rtl/sample_fifo.sv */
//************************************************************
// Synchronous FIFO, no reset on storage. Push while full and
// pop while empty are dropped. Head is visible before the pop.
//************************************************************

`timescale 1ns/1ps

module sample_fifo #(
	parameter type payload_t = logic [31:0],
	parameter int  DEPTH     = 8
) (
	input  logic                       i_clock,
	input  logic                       i_rst,
	input  logic                       i_push,
	input  payload_t                   i_wdata,
	input  logic                       i_pop,
	output payload_t                   o_head,
	output logic                       o_empty,
	output logic                       o_full,
	output logic [$clog2(DEPTH+1)-1:0] o_count
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic             do_push;
	logic             do_pop;

	assign do_push = i_push && !o_full;
	assign do_pop  = i_pop && !o_empty;

	assign o_empty = (o_count == CNT_W'(0));
	assign o_full  = (o_count == CNT_W'(DEPTH));

	// Oldest entry.
	assign o_head = mem[rd_ptr];

	// Storage, written only on an accepted push.
	always_ff @(posedge i_clock) begin
		if (do_push) begin
			mem[wr_ptr] <= i_wdata;
		end
	end

	// Pointers wrap at DEPTH so any depth works.
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			o_count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// Push and pop together keep the count.
			case ({do_push, do_pop})
				2'b10:   o_count <= o_count + 1'b1;
				2'b01:   o_count <= o_count - 1'b1;
				default: o_count <= o_count;
			endcase
		end
	end

endmodule

/* rtl/audio_controller.sv */
//************************************************************
// CPU register port: request, ready, request low, ready low.
// A data write to a full FIFO stalls ready until space exists.
//************************************************************

`timescale 1ns/1ps
`include "audio_cfg.svh"

module audio_controller (
	input  logic                                  i_clock,
	input  logic                                  i_rst,
	// CPU side.
	input  logic                                  i_request,
	input  audio_pkg::bus_req_t                   i_req,
	output logic [31:0]                           o_rdata,
	output logic                                  o_ready,
	// FIFO side.
	input  audio_pkg::stereo_sample_t             i_head,
	input  logic                                  i_empty,
	input  logic                                  i_full,
	input  logic [$clog2(`AUDIO_FIFO_DEPTH+1)-1:0] i_count,
	output logic                                  o_push,
	output audio_pkg::stereo_sample_t             o_push_data,
	output logic                                  o_pop,
	// Transmitter side.
	output logic                                  o_head_valid,
	output audio_pkg::stereo_sample_t             o_head,
	output logic [15:0]                           o_divider,
	input  logic                                  i_lrclk
);

	logic        is_write;
	logic        data_stall;
	logic        accept;
	logic [15:0] underrun_cnt;
	logic        lrclk_q;
	logic        lrclk_fall;
	logic        valid_q;
	logic        frame_pending;
	logic        frame_had_data;

	assign is_write   = i_req.rw;
	// A data write waits while the FIFO is full.
	assign data_stall = is_write && (i_req.address == `AUDIO_ADDR_DATA) && i_full;
	assign accept     = i_request && !o_ready && !data_stall;

	assign o_head_valid = !i_empty;
	assign o_head       = i_head;

	// Frame boundary of the transmitter.
	assign lrclk_fall = lrclk_q && !i_lrclk;

	// Pops only a sample the transmitter actually latched.
	assign o_pop = frame_pending && frame_had_data;

	// Handshake, divider and underrun counter.
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			o_ready      <= 1'b0;
			o_push       <= 1'b0;
			o_divider    <= `AUDIO_DEFAULT_DIVIDER;
			underrun_cnt <= '0;
		end else begin
			o_push <= 1'b0;
			if (accept) begin
				o_ready <= 1'b1;
				if (is_write) begin
					case (i_req.address)
						`AUDIO_ADDR_DATA:    o_push <= 1'b1;
						`AUDIO_ADDR_DIVIDER: begin
							o_divider <= (i_req.wdata[15:0] == 16'd0) ? 16'd1
								: i_req.wdata[15:0];
						end
						default: ;
					endcase
				end
			end else if (!i_request) begin
				o_ready <= 1'b0;
			end

			// A clear from the CPU wins over a new underrun.
			if (accept && is_write && (i_req.address == `AUDIO_ADDR_UNDERRUN)) begin
				underrun_cnt <= '0;
			end else if (frame_pending && !frame_had_data && (underrun_cnt != 16'hffff)) begin
				underrun_cnt <= underrun_cnt + 16'd1;
			end
		end
	end

	// Read data and push payload.
	always_ff @(posedge i_clock) begin
		if (accept) begin
			o_push_data.left  <= i_req.wdata[31:16];
			o_push_data.right <= i_req.wdata[15:0];
			case (i_req.address)
				`AUDIO_ADDR_DATA:     o_rdata <= audio_pkg::bus_word_t'(i_count);
				`AUDIO_ADDR_DIVIDER:  o_rdata <= audio_pkg::bus_word_t'(o_divider);
				`AUDIO_ADDR_UNDERRUN: o_rdata <= audio_pkg::bus_word_t'(underrun_cnt);
				default:              o_rdata <= '0;
			endcase
		end
	end

	// valid_q holds what the transmitter saw at the edge.
	// The pop or underrun lands two cycles after the edge.
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			lrclk_q        <= 1'b0;
			valid_q        <= 1'b0;
			frame_pending  <= 1'b0;
			frame_had_data <= 1'b0;
		end else begin
			lrclk_q        <= i_lrclk;
			valid_q        <= o_head_valid;
			frame_pending  <= lrclk_fall;
			frame_had_data <= lrclk_fall && valid_q;
		end
	end

endmodule

/* rtl/serial_audio_tx.sv */
//************************************************************
// Left-justified stereo transmitter, 16 bits per channel.
// Divider must be 1 or more. Frames without a sample are zero.
//************************************************************

`timescale 1ns/1ps

module serial_audio_tx (
	input  logic                      i_clock,
	input  logic                      i_rst,
	input  logic [15:0]               i_divider,
	input  audio_pkg::stereo_sample_t i_sample,
	input  logic                      i_sample_valid,
	output logic                      o_bclk,
	output logic                      o_lrclk,
	output logic                      o_sdata
);

	logic [15:0] tick_cnt;
	logic        tick;
	logic        bclk_fall;
	logic [4:0]  bit_cnt;
	logic [4:0]  bit_next;
	logic        frame_start;
	logic [31:0] frame_word;
	logic [31:0] shreg;

	// Tick counter.
	// A smaller divider written mid-count takes effect at once.
	assign tick = (tick_cnt >= i_divider - 16'd1);

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			tick_cnt <= '0;
		end else if (tick) begin
			tick_cnt <= '0;
		end else begin
			tick_cnt <= tick_cnt + 16'd1;
		end
	end

	// Bit clock is high, so this tick brings it low.
	assign bclk_fall = tick && o_bclk;

	// Wraps from 31 to 0.
	assign bit_next    = bit_cnt + 5'd1;
	assign frame_start = bclk_fall && (bit_cnt == 5'd31);

	// Left channel goes out first.
	assign frame_word = i_sample_valid ? {i_sample.left, i_sample.right} : 32'd0;

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			o_bclk <= 1'b0;
		end else if (tick) begin
			o_bclk <= !o_bclk;
		end
	end

	// Word select and data move together on falling bit clock.
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			bit_cnt <= '0;
			o_lrclk <= 1'b0;
			o_sdata <= 1'b0;
			shreg   <= '0;
		end else if (bclk_fall) begin
			bit_cnt <= bit_next;
			o_lrclk <= bit_next[4];
			if (frame_start) begin
				o_sdata <= frame_word[31];
				shreg   <= {frame_word[30:0], 1'b0};
			end else begin
				o_sdata <= shreg[31];
				shreg   <= {shreg[30:0], 1'b0};
			end
		end
	end

endmodule

/* rtl/audio_top.sv */
//************************************************************
// Audio playback subsystem, single clock domain on i_clock.
//************************************************************

`timescale 1ns/1ps
`include "audio_cfg.svh"

module audio_top (
	input  logic                i_clock,
	input  logic                i_rst,
	input  logic                i_request,
	input  audio_pkg::bus_req_t i_req,
	output logic [31:0]         o_rdata,
	output logic                o_ready,
	output logic                o_bclk,
	output logic                o_lrclk,
	output logic                o_sdata
);

	localparam int COUNT_W = $clog2(`AUDIO_FIFO_DEPTH + 1);

	audio_pkg::stereo_sample_t fifo_head;
	audio_pkg::stereo_sample_t push_data;
	audio_pkg::stereo_sample_t tx_sample;
	logic                      fifo_empty;
	logic                      fifo_full;
	logic [COUNT_W-1:0]        fifo_count;
	logic                      push;
	logic                      pop;
	logic                      tx_sample_valid;
	logic [15:0]               divider;

	sample_fifo #(
		.payload_t (audio_pkg::stereo_sample_t),
		.DEPTH     (`AUDIO_FIFO_DEPTH)
	) i_fifo (
		.i_clock (i_clock),
		.i_rst   (i_rst),
		.i_push  (push),
		.i_wdata (push_data),
		.i_pop   (pop),
		.o_head  (fifo_head),
		.o_empty (fifo_empty),
		.o_full  (fifo_full),
		.o_count (fifo_count)
	);

	audio_controller i_ctrl (
		.i_clock      (i_clock),
		.i_rst        (i_rst),
		.i_request    (i_request),
		.i_req        (i_req),
		.o_rdata      (o_rdata),
		.o_ready      (o_ready),
		.i_head       (fifo_head),
		.i_empty      (fifo_empty),
		.i_full       (fifo_full),
		.i_count      (fifo_count),
		.o_push       (push),
		.o_push_data  (push_data),
		.o_pop        (pop),
		.o_head_valid (tx_sample_valid),
		.o_head       (tx_sample),
		.o_divider    (divider),
		.i_lrclk      (o_lrclk)
	);

	serial_audio_tx i_tx (
		.i_clock        (i_clock),
		.i_rst          (i_rst),
		.i_divider      (divider),
		.i_sample       (tx_sample),
		.i_sample_valid (tx_sample_valid),
		.o_bclk         (o_bclk),
		.o_lrclk        (o_lrclk),
		.o_sdata        (o_sdata)
	);

endmodule

/* tests/audio_tb.sv */
//************************************************************
// Trace-driven testbench for audio_top. Run from the project
// root; reads tests/audio_trace.txt.
//************************************************************

`timescale 1ns/1ps
`include "audio_cfg.svh"

module audio_tb;

	localparam int MAX_FRAMES    = 512;
	localparam int READY_LIMIT   = 2000;
	localparam int SETTLE_CYCLES = 4;
	localparam     TRACE_PATH    = "tests/audio_trace.txt";

	logic                i_clock;
	logic                i_rst;
	logic                i_request;
	audio_pkg::bus_req_t i_req;
	logic [31:0]         o_rdata;
	logic                o_ready;
	logic                o_bclk;
	logic                o_lrclk;
	logic                o_sdata;

	int          read_errors  = 0;
	int          frame_errors = 0;
	int          other_errors = 0;
	int          cycles       = 0;
	int          cycle_limit  = 0;
	int          lr_falls     = 0;
	int          cursor       = 0;
	int          bit_pos      = 32;
	int          cur_frame    = 0;
	logic        prev_lrclk   = 1'b0;
	int          bclk_div     = `AUDIO_DEFAULT_DIVIDER;
	int          bclk_run     = 0;
	int          bclk_skip    = 1;
	logic        bclk_last    = 1'b0;
	logic        ready_last   = 1'b0;
	logic [31:0] shift_word;
	logic [31:0] frame_data [MAX_FRAMES];
	logic        frame_done [MAX_FRAMES];

	audio_top i_dut (
		.i_clock   (i_clock),
		.i_rst     (i_rst),
		.i_request (i_request),
		.i_req     (i_req),
		.o_rdata   (o_rdata),
		.o_ready   (o_ready),
		.o_bclk    (o_bclk),
		.o_lrclk   (o_lrclk),
		.o_sdata   (o_sdata)
	);

	always #5 i_clock = ~i_clock;

	always @(posedge i_clock) begin
		cycles++;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("Timeout: the run went past its limit of %0d cycles", cycle_limit);
			$display("Errors: %0d read, %0d frame, %0d other",
				read_errors, frame_errors, other_errors);
			$display("Simulation failed");
			$finish;
		end
	end

	// Frame k is the one that starts at the k-th falling word select.
	always @(negedge o_lrclk) begin
		if (!i_rst) begin
			lr_falls++;
		end
	end

	// Capture on rising bit clock, MSB first.
	always @(posedge o_bclk) begin
		if (!i_rst) begin
			if (!o_lrclk && prev_lrclk) begin
				cur_frame = lr_falls;
				bit_pos   = 0;
			end
			if (bit_pos < 32) begin
				if (o_lrclk !== (bit_pos >= 16)) begin
					$display("ERR o_lrclk frame %0d bit %0d: expected %h, got %h",
						cur_frame, bit_pos, (bit_pos >= 16), o_lrclk);
					frame_errors++;
				end
				shift_word = {shift_word[30:0], o_sdata};
				bit_pos++;
				if (bit_pos == 32 && cur_frame < MAX_FRAMES) begin
					frame_data[cur_frame] = shift_word;
					frame_done[cur_frame] = 1'b1;
				end
			end
			prev_lrclk = o_lrclk;
		end
	end

	// Bit clock half period against the divider last written.
	// The interval in which the divider changes is not measured.
	always @(negedge i_clock) begin
		if (i_rst) begin
			bclk_run   = 0;
			bclk_skip  = 1;
			bclk_last  = 1'b0;
			ready_last = 1'b0;
		end else begin
			bclk_run++;
			if (o_bclk !== bclk_last) begin
				if (bclk_skip > 0) begin
					bclk_skip--;
				end else if (bclk_run != bclk_div) begin
					$display("ERR o_bclk half period: expected %0h, got %0h",
						bclk_div, bclk_run);
					frame_errors++;
				end
				bclk_last = o_bclk;
				bclk_run  = 0;
			end
			if (o_ready && !ready_last && i_req.rw
					&& i_req.address == `AUDIO_ADDR_DIVIDER) begin
				bclk_div  = (i_req.wdata[15:0] == 16'd0) ? 1 : i_req.wdata[15:0];
				bclk_skip = 1;
			end
			ready_last = o_ready;
		end
	end

	// One request, ready, request low, ready low cycle.
	task automatic bus_op(input logic rw, input logic [3:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic ok);
		int waited;
		ok = 1'b1;
		@(negedge i_clock);
		i_req.rw      = rw;
		i_req.address = addr;
		i_req.wdata   = wdata;
		i_request     = 1'b1;
		waited        = 0;
		@(negedge i_clock);
		// A data write may stall here on a full FIFO.
		while (!o_ready && waited < READY_LIMIT) begin
			@(negedge i_clock);
			waited++;
		end
		rdata = o_rdata;
		if (!o_ready) begin
			$display("Bus %s at address %h got no ready within %0d cycles",
				rw ? "write" : "read", addr, READY_LIMIT);
			other_errors++;
			ok = 1'b0;
		end
		i_request = 1'b0;
		waited    = 0;
		while (o_ready && waited < READY_LIMIT) begin
			@(negedge i_clock);
			waited++;
		end
		if (o_ready) begin
			$display("Ready stayed high after the request at address %h dropped", addr);
			other_errors++;
			ok = 1'b0;
		end
	endtask

	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
		logic [31:0] rdata;
		logic        ok;
		bus_op(1'b1, addr, data, rdata, ok);
	endtask

	task automatic read_reg(input logic [3:0] addr, input logic [31:0] expected);
		logic [31:0] rdata;
		logic        ok;
		bus_op(1'b0, addr, 32'd0, rdata, ok);
		if (ok && rdata !== expected) begin
			$display("ERR o_rdata addr %h: expected %08h, got %08h", addr, expected, rdata);
			read_errors++;
		end
	endtask

	// Marks the next frame to start, then waits for count frame starts.
	// The pop or underrun of each start lands 2 cycles after it.
	task automatic wait_frames(input int count);
		int base;
		base   = lr_falls;
		cursor = base + 1;
		while (lr_falls < base + count) begin
			@(negedge i_clock);
		end
		if (count > 0) begin
			repeat (SETTLE_CYCLES) @(negedge i_clock);
		end
	endtask

	task automatic check_frame(input logic [15:0] left, input logic [15:0] right);
		if (cursor >= MAX_FRAMES) begin
			$display("Frame %0d lies beyond the capture buffer", cursor);
			other_errors++;
		end else begin
			while (!frame_done[cursor]) begin
				@(negedge i_clock);
			end
			if (frame_data[cursor] !== {left, right}) begin
				$display("ERR o_sdata frame %0d: expected %08h, got %08h",
					cursor, {left, right}, frame_data[cursor]);
				frame_errors++;
			end
		end
		cursor++;
	endtask

	// Next command of the trace. Lines starting with # are skipped.
	task automatic next_command(input int fd, output logic [7:0] op,
			output logic [31:0] arg_a, output logic [31:0] arg_b, output logic got);
		int    n;
		string rest;
		got   = 1'b0;
		arg_a = '0;
		arg_b = '0;
		op    = "#";
		while (op == "#") begin
			n = $fscanf(fd, " %c", op);
			if (n != 1) begin
				return;
			end
			if (op == "#") begin
				n = $fgets(rest, fd);
			end
		end
		case (op)
			"N":           n = $fscanf(fd, "%d", arg_a);
			"F", "W", "R": n = $fscanf(fd, "%h %h", arg_a, arg_b);
			default:       n = 0;
		endcase
		got = 1'b1;
	endtask

	task automatic count_trace(input int fd, output int frames, output int bus_lines);
		logic [7:0]  op;
		logic [31:0] arg_a;
		logic [31:0] arg_b;
		logic        got;
		frames    = 0;
		bus_lines = 0;
		got       = 1'b1;
		while (got) begin
			next_command(fd, op, arg_a, arg_b, got);
			if (got && op == "F") begin
				frames++;
			end else if (got && op == "N") begin
				frames += arg_a;
			end else if (got) begin
				bus_lines++;
			end
		end
	endtask

	task automatic run_trace(input int fd);
		logic [7:0]  op;
		logic [31:0] arg_a;
		logic [31:0] arg_b;
		logic        got;
		got = 1'b1;
		while (got) begin
			next_command(fd, op, arg_a, arg_b, got);
			if (got) begin
				case (op)
					"W": write_reg(arg_a[3:0], arg_b);
					"R": read_reg(arg_a[3:0], arg_b);
					"F": check_frame(arg_a[15:0], arg_b[15:0]);
					"N": wait_frames(arg_a);
					default: begin
						$display("Unknown trace command %c", op);
						other_errors++;
					end
				endcase
			end
		end
	endtask

	initial begin
		int fd;
		int frames;
		int bus_lines;
		i_clock   = 1'b0;
		i_rst     = 1'b1;
		i_request = 1'b0;
		i_req     = '0;
		for (int i = 0; i < MAX_FRAMES; i++) begin
			frame_done[i] = 1'b0;
		end
		fd = $fopen(TRACE_PATH, "r");
		if (fd == 0) begin
			$display("Cannot open the trace file %s", TRACE_PATH);
			other_errors++;
		end else begin
			count_trace(fd, frames, bus_lines);
			$fclose(fd);
			// Two extra frames cover start-up and alignment.
			cycle_limit = (frames + 2) * 64 * `AUDIO_DEFAULT_DIVIDER + 200 * bus_lines;
			repeat (5) @(negedge i_clock);
			i_rst = 1'b0;
			fd = $fopen(TRACE_PATH, "r");
			run_trace(fd);
			$fclose(fd);
		end
		$display("Errors: %0d read, %0d frame, %0d other",
			read_errors, frame_errors, other_errors);
		if (read_errors + frame_errors + other_errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* tb.f */
+incdir+rtl
rtl/audio_pkg.sv
rtl/sample_fifo.sv
rtl/audio_controller.sv
rtl/serial_audio_tx.sv
rtl/audio_top.sv
tests/audio_tb.sv

/* tests/audio_trace.txt */
# W addr data | R addr expected data | F expected left right (all hex)
# N count (decimal) marks the next frame and waits for that many frame starts
# After reset
R 1 00000011
R 0 00000000
R 2 00000000
# Divider register
W 1 00000002
R 1 00000002
W 1 00000000
R 1 00000001
W 1 00000002
R 1 00000002
# Three samples in order
N 1
W 0 12345678
W 0 8001ffff
W 0 7fff0000
R 0 00000003
N 0
F 1234 5678
F 8001 ffff
F 7fff 0000
# Underruns while empty
N 1
W 2 00000000
N 3
R 2 00000003
W 2 00000000
R 2 00000000
F 0000 0000
F 0000 0000
F 0000 0000
# Full FIFO and a stalled ninth write
N 1
W 0 01010202
W 0 03030404
W 0 05050606
W 0 07070808
W 0 09090a0a
W 0 0b0b0c0c
W 0 0d0d0e0e
W 0 0f0f1010
R 0 00000008
N 0
W 0 a5a55a5a
R 0 00000008
F 0101 0202
F 0303 0404
F 0505 0606
F 0707 0808
F 0909 0a0a
F 0b0b 0c0c
F 0d0d 0e0e
F 0f0f 1010
F a5a5 5a5a
# Unmapped address
N 1
W 2 00000000
W 3 ffffffff
R 3 00000000
R 1 00000002
R 0 00000000
R 2 00000000
